/* sme_pkg.sv */
package sme_pkg;

    // One text or pattern character
    typedef logic [7:0] char_t;

    // Pattern tokens
    localparam char_t char_any   = 8'h2E; // '.' matches any one character
    localparam char_t char_head  = 8'h5E; // '^' only as the first pattern character
    localparam char_t char_tail  = 8'h24; // '$' only as the last pattern character

    // Word boundary for the anchors, also returned for positions outside the string
    localparam char_t char_space = 8'h20;

    // Search FSM of the match engine
    typedef enum logic [1:0] {
        st_idle = 2'd0,
        st_scan = 2'd1,
        st_done = 2'd2
    } engine_state_t;

endpackage

/* string_buffer.sv */
module string_buffer import sme_pkg::*; #(
    parameter int max_string_len  = 32,
    parameter int max_pattern_len = 8
) (
    input  logic                                       clk,
    input  logic                                       reset,
    input  char_t                                      chardata,
    input  logic                                       isstring,
    input  logic [$clog2(max_string_len)-1:0]          window_start,
    output char_t [max_pattern_len:0]                  window_chars,
    output char_t                                      char_before,
    output logic [$clog2(max_string_len+1)-1:0]        string_len
);

    localparam int idx_w = $clog2(max_string_len);
    localparam int len_w = $clog2(max_string_len + 1);
    localparam int pos_w = $clog2(max_string_len + max_pattern_len + 1);

    typedef logic [idx_w-1:0] index_t;
    typedef logic [len_w-1:0] len_t;
    typedef logic [pos_w-1:0] pos_t;

    char_t  mem [max_string_len];
    logic   isstring_d;
    logic   first_char;
    logic   wr_en;
    index_t wr_addr;
    pos_t   rd_pos;

    assign first_char = isstring && !isstring_d; // A new run overwrites the old string
    assign wr_en      = first_char || (isstring && string_len < max_string_len);
    assign wr_addr    = first_char ? '0 : string_len[idx_w-1:0];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            isstring_d <= 1'b0;
            string_len <= '0;
        end else begin
            isstring_d <= isstring;
            if (first_char) begin
                string_len <= len_t'(1);
            end else if (wr_en) begin
                string_len <= string_len + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= chardata;
        end
    end

    // One lane more than the pattern so the engine can see the character after the core
    always_comb begin
        for (int i = 0; i <= max_pattern_len; i++) begin
            rd_pos = pos_t'(window_start) + pos_t'(i);
            window_chars[i] = (rd_pos < string_len) ? mem[rd_pos[idx_w-1:0]] : char_space;
        end
    end

    always_comb begin
        if (window_start == '0 || len_t'(window_start) > string_len) begin
            char_before = char_space; // String start counts as a boundary
        end else begin
            char_before = mem[window_start - 1'b1];
        end
    end

    a_len_in_range: assert property (@(posedge clk) disable iff (reset)
        string_len <= max_string_len)
        else $error("string_len %0d above capacity", string_len);

endmodule

/* pattern_decoder.sv */
module pattern_decoder import sme_pkg::*; #(
    parameter int max_pattern_len = 8
) (
    input  logic                                        clk,
    input  logic                                        reset,
    input  char_t                                       chardata,
    input  logic                                        ispattern,
    output char_t [max_pattern_len-1:0]                 lane_chars,
    output logic  [max_pattern_len-1:0]                 lane_any,
    output logic  [$clog2(max_pattern_len+1)-1:0]       core_len,
    output logic                                        anchor_head,
    output logic                                        anchor_tail,
    output logic                                        pattern_ready
);

    localparam int pidx_w = $clog2(max_pattern_len);
    localparam int cnt_w  = $clog2(max_pattern_len + 1);

    typedef logic [pidx_w-1:0] pidx_t;
    typedef logic [cnt_w-1:0]  cnt_t;

    char_t raw [max_pattern_len];
    cnt_t  raw_len;
    logic  ispattern_d;
    logic  first_char;
    logic  wr_en;
    pidx_t wr_addr;
    logic  run_end;
    pidx_t last_idx;

    char_t [max_pattern_len-1:0] lane_chars_c;
    logic  [max_pattern_len-1:0] lane_any_c;
    logic                        head_c;
    logic                        tail_c;
    cnt_t                        core_c;

    assign first_char = ispattern && !ispattern_d;
    assign wr_en      = first_char || (ispattern && raw_len < max_pattern_len);
    assign wr_addr    = first_char ? '0 : raw_len[pidx_w-1:0];
    assign run_end    = ispattern_d && !ispattern;
    assign last_idx   = pidx_t'(raw_len - cnt_t'(1));

    always_ff @(posedge clk) begin
        if (wr_en) begin
            raw[wr_addr] <= chardata;
        end
    end

    always_comb begin
        head_c = (raw_len != '0) && (raw[0] == char_head);
        tail_c = (raw_len != '0) && (raw[last_idx] == char_tail);
        core_c = raw_len - cnt_t'(head_c) - cnt_t'(tail_c);
        for (int k = 0; k < max_pattern_len; k++) begin
            if (k < core_c) begin
                lane_chars_c[k] = raw[pidx_t'(k + int'(head_c))]; // Skip a leading '^'
                lane_any_c[k]   = (lane_chars_c[k] == char_any);
            end else begin
                lane_chars_c[k] = char_space;
                lane_any_c[k]   = 1'b0;
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ispattern_d   <= 1'b0;
            raw_len       <= '0;
            pattern_ready <= 1'b0;
            core_len      <= '0;
            anchor_head   <= 1'b0;
            anchor_tail   <= 1'b0;
        end else begin
            ispattern_d   <= ispattern;
            pattern_ready <= run_end;
            if (first_char) begin
                raw_len <= cnt_t'(1);
            end else if (wr_en) begin
                raw_len <= raw_len + 1'b1;
            end
            if (run_end) begin
                core_len    <= core_c;
                anchor_head <= head_c;
                anchor_tail <= tail_c;
            end
        end
    end

    // Lanes only change at the end of a run and stay put for the whole search
    always_ff @(posedge clk) begin
        if (run_end) begin
            lane_chars <= lane_chars_c;
            lane_any   <= lane_any_c;
        end
    end

    a_pattern_fits: assert property (@(posedge clk) disable iff (reset)
        ispattern && ispattern_d |-> raw_len < max_pattern_len)
        else $error("pattern run longer than %0d characters", max_pattern_len);

endmodule

/* match_engine.sv */
module match_engine import sme_pkg::*; #(
    parameter int max_string_len  = 32,
    parameter int max_pattern_len = 8
) (
    input  logic                                        clk,
    input  logic                                        reset,
    input  logic                                        pattern_ready,
    input  logic                                        ispattern,
    input  logic                                        isstring,
    input  char_t [max_pattern_len-1:0]                 lane_chars,
    input  logic  [max_pattern_len-1:0]                 lane_any,
    input  logic  [$clog2(max_pattern_len+1)-1:0]       core_len,
    input  logic                                        anchor_head,
    input  logic                                        anchor_tail,
    input  char_t [max_pattern_len:0]                   window_chars,
    input  char_t                                       char_before,
    input  logic  [$clog2(max_string_len+1)-1:0]        string_len,
    output logic  [$clog2(max_string_len)-1:0]          window_start,
    output logic                                        search_done,
    output logic                                        found,
    output logic  [$clog2(max_string_len)-1:0]          found_index
);

    localparam int len_w = $clog2(max_string_len + 1);

    typedef logic [len_w-1:0] len_t;

    engine_state_t state;
    engine_state_t next_state;

    logic [max_pattern_len-1:0] lane_ok;
    logic                       head_ok;
    logic                       tail_ok;
    logic                       fit;
    logic                       too_short;
    logic                       at_last;
    len_t                       last_start;

    // Lanes above the core always pass
    always_comb begin
        for (int k = 0; k < max_pattern_len; k++) begin
            lane_ok[k] = (k >= core_len) || lane_any[k] || (lane_chars[k] == window_chars[k]);
        end
    end

    // The buffer returns a space outside the string so both ends count as boundaries
    assign head_ok = !anchor_head || (char_before == char_space);
    assign tail_ok = !anchor_tail || (window_chars[core_len] == char_space);
    assign fit     = (&lane_ok) && head_ok && tail_ok;

    assign too_short  = string_len < len_t'(core_len);
    assign last_start = string_len - len_t'(core_len);
    assign at_last    = len_t'(window_start) >= last_start;

    always_comb begin
        next_state = state;
        case (state)
            st_idle: begin
                if (pattern_ready) begin
                    next_state = st_scan;
                end
            end
            st_scan: begin
                if (too_short || fit || at_last) begin
                    next_state = st_done;
                end
            end
            st_done: next_state = st_idle;
            default: next_state = st_idle;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= st_idle;
        end else begin
            state <= next_state;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            window_start <= '0;
            found        <= 1'b0;
            found_index  <= '0;
        end else begin
            if (state == st_idle && pattern_ready) begin
                window_start <= '0;
                found        <= 1'b0;
            end else if (state == st_scan) begin
                if (too_short) begin
                    found <= 1'b0;
                end else if (fit) begin
                    found       <= 1'b1; // First fit wins since positions rise
                    found_index <= window_start;
                end else if (at_last) begin
                    found <= 1'b0;
                end else begin
                    window_start <= window_start + 1'b1;
                end
            end
        end
    end

    assign search_done = (state == st_done);

    a_host_quiet: assert property (@(posedge clk) disable iff (reset)
        state != st_idle |-> !(ispattern || isstring))
        else $error("host input during search in state %s", state.name());

    a_window_in_string: assert property (@(posedge clk) disable iff (reset)
        state == st_scan && !too_short && core_len != '0 |-> len_t'(window_start) < string_len)
        else $error("window_start %0d outside string of %0d", window_start, string_len);

endmodule

/* result_reporter.sv */
module result_reporter import sme_pkg::*; #(
    parameter int max_string_len = 32
) (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 search_done,
    input  logic                                 found,
    input  logic [$clog2(max_string_len)-1:0]    found_index,
    output logic                                 valid,
    output logic                                 match,
    output logic [$clog2(max_string_len)-1:0]    match_index
);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            valid       <= 1'b0;
            match       <= 1'b0;
            match_index <= '0;
        end else begin
            valid <= search_done; // One pulse per finished search
            if (search_done) begin
                match       <= found;
                match_index <= found ? found_index : '0;
            end
        end
    end

    a_valid_pulse: assert property (@(posedge clk) disable iff (reset)
        valid |=> !valid)
        else $error("valid high on two consecutive cycles");

endmodule

/* sme.sv */
module sme import sme_pkg::*; #(
    parameter int max_string_len  = 32,
    parameter int max_pattern_len = 8
) (
    input  logic                                 clk,
    input  logic                                 reset,
    input  char_t                                chardata,
    input  logic                                 isstring,
    input  logic                                 ispattern,
    output logic                                 valid,
    output logic                                 match,
    output logic [$clog2(max_string_len)-1:0]    match_index
);

    localparam int idx_w = $clog2(max_string_len);
    localparam int len_w = $clog2(max_string_len + 1);
    localparam int cnt_w = $clog2(max_pattern_len + 1);

    logic [idx_w-1:0]            window_start;
    char_t [max_pattern_len:0]   window_chars;
    char_t                       char_before;
    logic [len_w-1:0]            string_len;
    char_t [max_pattern_len-1:0] lane_chars;
    logic [max_pattern_len-1:0]  lane_any;
    logic [cnt_w-1:0]            core_len;
    logic                        anchor_head;
    logic                        anchor_tail;
    logic                        pattern_ready;
    logic                        search_done;
    logic                        found;
    logic [idx_w-1:0]            found_index;

    string_buffer #(
        .max_string_len  (max_string_len),
        .max_pattern_len (max_pattern_len)
    ) u_string_buffer (
        .clk          (clk),
        .reset        (reset),
        .chardata     (chardata),
        .isstring     (isstring),
        .window_start (window_start),
        .window_chars (window_chars),
        .char_before  (char_before),
        .string_len   (string_len)
    );

    pattern_decoder #(
        .max_pattern_len (max_pattern_len)
    ) u_pattern_decoder (
        .clk           (clk),
        .reset         (reset),
        .chardata      (chardata),
        .ispattern     (ispattern),
        .lane_chars    (lane_chars),
        .lane_any      (lane_any),
        .core_len      (core_len),
        .anchor_head   (anchor_head),
        .anchor_tail   (anchor_tail),
        .pattern_ready (pattern_ready)
    );

    match_engine #(
        .max_string_len  (max_string_len),
        .max_pattern_len (max_pattern_len)
    ) u_match_engine (
        .clk           (clk),
        .reset         (reset),
        .pattern_ready (pattern_ready),
        .ispattern     (ispattern),
        .isstring      (isstring),
        .lane_chars    (lane_chars),
        .lane_any      (lane_any),
        .core_len      (core_len),
        .anchor_head   (anchor_head),
        .anchor_tail   (anchor_tail),
        .window_chars  (window_chars),
        .char_before   (char_before),
        .string_len    (string_len),
        .window_start  (window_start),
        .search_done   (search_done),
        .found         (found),
        .found_index   (found_index)
    );

    result_reporter #(
        .max_string_len (max_string_len)
    ) u_result_reporter (
        .clk         (clk),
        .reset       (reset),
        .search_done (search_done),
        .found       (found),
        .found_index (found_index),
        .valid       (valid),
        .match       (match),
        .match_index (match_index)
    );

endmodule

/* sme_tb_model.svh */
`ifndef sme_tb_model_svh
`define sme_tb_model_svh

// First start position where the core fits, with '^' and '$' stripped off as anchors
function automatic void expected_result(input string text, input string pat,
                                        output logic hit, output logic [4:0] index);
    int   head;
    int   tail;
    int   m;
    int   len;
    logic ok;
    head  = (pat.len() > 0 && pat[0] == "^") ? 1 : 0;
    tail  = (pat.len() > 0 && pat[pat.len() - 1] == "$") ? 1 : 0;
    m     = pat.len() - head - tail;
    len   = text.len();
    hit   = 1'b0;
    index = '0;
    for (int s = 0; s + m <= len && !hit; s++) begin
        ok = 1'b1;
        for (int k = 0; k < m; k++) begin
            if (pat[k + head] != "." && pat[k + head] != text[s + k]) begin
                ok = 1'b0;
            end
        end
        if (head == 1 && s > 0 && text[s - 1] != " ") begin
            ok = 1'b0; // Needs a word start
        end
        if (tail == 1 && s + m < len && text[s + m] != " ") begin
            ok = 1'b0;
        end
        if (ok) begin
            hit   = 1'b1;
            index = 5'(s);
        end
    end
endfunction

function automatic string random_text(input int n);
    string s;
    s = "";
    for (int i = 0; i < n; i++) begin
        case ($urandom_range(0, 2))
            0: s = {s, "a"};
            1: s = {s, "b"};
            default: s = {s, " "};
        endcase
    end
    return s;
endfunction

// Anchors count against the raw pattern length
function automatic string random_pattern(input int max_len);
    string s;
    int    head;
    int    tail;
    int    n;
    head = $urandom_range(0, 1);
    tail = $urandom_range(0, 1);
    n    = $urandom_range(1, max_len - head - tail);
    s    = "";
    if (head == 1) begin
        s = "^";
    end
    for (int i = 0; i < n; i++) begin
        case ($urandom_range(0, 2))
            0: s = {s, "a"};
            1: s = {s, "b"};
            default: s = {s, "."};
        endcase
    end
    if (tail == 1) begin
        s = {s, "$"};
    end
    return s;
endfunction

`endif

/* sme_tb.sv */
module sme_tb;

    localparam int max_string_len    = 32;
    localparam int max_pattern_len   = 8;
    localparam int num_directed      = 12;
    localparam int num_random_texts  = 40;
    localparam int patterns_per_text = 2;
    localparam int num_cases         = num_directed + num_random_texts * patterns_per_text;
    localparam int case_cycles       = 40 + max_string_len + 4;

    logic       clk;
    logic       reset;
    logic [7:0] chardata;
    logic       isstring;
    logic       ispattern;
    logic       valid;
    logic       match;
    logic [4:0] match_index;

    string      cur_text;
    logic       exp_match;
    logic [4:0] exp_index;
    logic       pending; // A pattern was sent and its valid is still due

    `include "sme_tb_model.svh"

    sme #(
        .max_string_len  (max_string_len),
        .max_pattern_len (max_pattern_len)
    ) uut (
        .clk         (clk),
        .reset       (reset),
        .chardata    (chardata),
        .isstring    (isstring),
        .ispattern   (ispattern),
        .valid       (valid),
        .match       (match),
        .match_index (match_index)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        #(num_cases * case_cycles * 4);
        $display("Timeout: the run did not finish within the time allowed for %0d cases",
                 num_cases);
        $display("CHECKS FAILED");
        $fatal(1);
    end

    a_match_value: assert property (@(posedge clk) disable iff (reset)
        valid |-> match == exp_match)
        else begin
            $display("CHECK FAILED match: got %h expected %h",
                     $sampled(match), $sampled(exp_match));
            $display("CHECKS FAILED");
            $fatal(1);
        end

    a_index_value: assert property (@(posedge clk) disable iff (reset)
        valid |-> match_index == exp_index)
        else begin
            $display("CHECK FAILED match_index: got %h expected %h",
                     $sampled(match_index), $sampled(exp_index));
            $display("CHECKS FAILED");
            $fatal(1);
        end

    a_valid_expected: assert property (@(posedge clk) disable iff (reset)
        valid |-> pending)
        else begin
            $display("A valid pulse arrived while no pattern was outstanding");
            $display("CHECKS FAILED");
            $fatal(1);
        end

    task automatic load_string(input string text);
        for (int i = 0; i < text.len(); i++) begin
            chardata = text[i];
            isstring = 1'b1;
            @(posedge clk);
            #1;
        end
        isstring = 1'b0;
        chardata = '0;
        cur_text = text;
        @(posedge clk); // Idle cycle before the pattern
        #1;
    endtask

    task automatic wait_for_valid();
        int waited;
        waited = 0;
        while (!valid) begin
            if (waited > max_string_len + 8) begin
                $display("No valid pulse within %0d cycles after the pattern", waited);
                $display("CHECKS FAILED");
                $fatal(1);
            end
            @(posedge clk);
            #1;
            waited++;
        end
        @(posedge clk); // Keeps pending up while the checks sample this valid
        #1;
        pending = 1'b0;
    endtask

    task automatic search_pattern(input string pat);
        expected_result(cur_text, pat, exp_match, exp_index);
        pending = 1'b1;
        for (int i = 0; i < pat.len(); i++) begin
            chardata  = pat[i];
            ispattern = 1'b1;
            @(posedge clk);
            #1;
        end
        ispattern = 1'b0;
        chardata  = '0;
        wait_for_valid();
    endtask

    initial begin
        reset      = 1'b1;
        chardata   = '0;
        isstring   = 1'b0;
        ispattern  = 1'b0;
        pending    = 1'b0;
        exp_match  = 1'b0;
        exp_index  = '0;
        cur_text   = "";
        void'($urandom(29371));
        repeat (3) @(posedge clk);
        #1;
        reset = 1'b0;

        load_string("abcabc");
        search_pattern("bc");
        search_pattern("abc");
        load_string("hello world");
        search_pattern("w.r");
        search_pattern("l.o");
        load_string("cat concat");
        search_pattern("^cat");
        search_pattern("^con");
        search_pattern("^at");
        load_string("concat cat");
        search_pattern("cat$");
        search_pattern("con$");
        load_string("abc");
        search_pattern("xyz");
        search_pattern("abcd");
        load_string("ab"); // Shorter than the previous string, so old characters must be gone
        search_pattern("bc");

        for (int t = 0; t < num_random_texts; t++) begin
            load_string(random_text($urandom_range(1, max_string_len)));
            for (int p = 0; p < patterns_per_text; p++) begin
                search_pattern(random_pattern(max_pattern_len));
            end
        end

        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

/* sme.f */
+incdir+.
sme_pkg.sv
string_buffer.sv
pattern_decoder.sv
match_engine.sv
result_reporter.sv
sme.sv
sme_tb.sv
